// ==== source/pkt_pkg.sv ====
package pkt_pkg;

    // Data widths of the wide packet memory and the narrow stream side.
    localparam int MEM_WIDTH = 64;
    localparam int FWD_WIDTH = 32;
    localparam int RATIO     = MEM_WIDTH / FWD_WIDTH; // Narrow words per memory word.

    // Address widths. The narrow address has one extra bit per doubling of width.
    localparam int MEM_ADDR_WIDTH = 9;
    localparam int FWD_ADDR_WIDTH = 10;
    localparam int OFS_WIDTH      = FWD_ADDR_WIDTH - MEM_ADDR_WIDTH; // Lane offset bits.
    localparam int MEM_DEPTH      = 1 << MEM_ADDR_WIDTH;

    localparam int MEM_LAT   = 1;  // Read latency of the packet memory in cycles.
    localparam int LEN_WIDTH = 11; // Holds lengths from 1 up to and including 1024.

    typedef logic [MEM_WIDTH-1:0]      mem_word_t;
    typedef logic [FWD_WIDTH-1:0]      fwd_word_t;
    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [FWD_ADDR_WIDTH-1:0] fwd_addr_t;
    typedef logic [LEN_WIDTH-1:0]      pkt_len_t;
    typedef logic [RATIO-1:0]          lane_en_t; // Bit 1 is the upper lane.

    // One write into the packet memory. Nothing is written when en is all zero.
    typedef struct packed {
        lane_en_t  en;
        mem_addr_t addr;
        mem_word_t data;
    } mem_wr_t;

    // The forwarder either waits for a packet or streams one out.
    typedef enum logic {
        idle,
        send
    } fwd_state_t;

endpackage

// ==== source/packet_mem.sv ====
`timescale 1ns/1ns

module packet_mem (
    input  logic               clk,
    input  pkt_pkg::mem_wr_t   mem_wr,      // Lane-enabled write from the snooper.
    input  pkt_pkg::mem_addr_t mem_addr,    // Read address from the adapter.
    output pkt_pkg::mem_word_t mem_rd_data  // Valid MEM_LAT cycles after mem_addr.
);

    // The storage array, one wide word per entry.
    pkt_pkg::mem_word_t mem [pkt_pkg::MEM_DEPTH];

    // Read data pipeline. Stage 0 is the array read itself.
    pkt_pkg::mem_word_t rd_pipe [pkt_pkg::MEM_LAT];

    // Each lane has its own enable, so the snooper can fill one narrow word at
    // a time without a read-modify-write of the whole memory word.
    always_ff @(posedge clk) begin
        for (int i = 0; i < pkt_pkg::RATIO; i++) begin
            if (mem_wr.en[i]) begin
                mem[mem_wr.addr][i*pkt_pkg::FWD_WIDTH +: pkt_pkg::FWD_WIDTH] <=
                    mem_wr.data[i*pkt_pkg::FWD_WIDTH +: pkt_pkg::FWD_WIDTH];
            end
        end
    end

    // The read port is registered. A read of an entry that is written at the
    // same edge returns the old contents, which never happens in practice
    // because the snooper and the forwarder do not run at the same time.
    always_ff @(posedge clk) begin
        rd_pipe[0] <= mem[mem_addr];
        for (int i = 1; i < pkt_pkg::MEM_LAT; i++) begin
            rd_pipe[i] <= rd_pipe[i-1]; // Extra stages only when MEM_LAT is above 1.
        end
    end

    assign mem_rd_data = rd_pipe[pkt_pkg::MEM_LAT-1]; // Last stage drives the port.

endmodule

// ==== source/snooper.sv ====
`timescale 1ns/1ns

module snooper (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,  // One word of the packet is on in_data.
    input  logic               in_last,   // The word on in_data ends the packet.
    input  pkt_pkg::fwd_word_t in_data,
    input  logic               fwd_busy,  // The forwarder still owns the memory.
    output pkt_pkg::mem_wr_t   mem_wr,
    output logic               pkt_ready, // One-cycle pulse after the last word.
    output pkt_pkg::pkt_len_t  pkt_len,   // Length in words, valid with pkt_ready.
    output logic               receiving  // A packet is partly stored.
);

    pkt_pkg::fwd_addr_t wr_ptr; // Narrow address of the next word to store.
    logic               accept; // The word on in_data is taken this cycle.

    // Only one packet fits in the memory. A word that arrives while the previous
    // packet is still handed over or streamed out would overwrite it, so such a
    // word is ignored here and flagged by the protocol checker.
    assign accept = in_valid && !fwd_busy && !pkt_ready;

    // The low pointer bits choose the lane. Word 0 of each pair goes to the
    // upper lane, which gives the big-endian order that the adapter expects.
    always_comb begin
        mem_wr.addr = wr_ptr[pkt_pkg::FWD_ADDR_WIDTH-1:pkt_pkg::OFS_WIDTH];
        mem_wr.data = {pkt_pkg::RATIO{in_data}}; // Same word copied into every lane.
        mem_wr.en   = '0;
        if (accept) begin
            mem_wr.en = pkt_pkg::lane_en_t'(1) <<
                (pkt_pkg::RATIO - 1 - int'(wr_ptr[pkt_pkg::OFS_WIDTH-1:0]));
        end
    end

    // Control state. The pointer goes back to zero at the end of every packet
    // so the next packet starts at memory word 0.
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            pkt_ready <= 1'b0;
            receiving <= 1'b0;
        end else begin
            pkt_ready <= 1'b0; // A pulse unless set again below.
            if (accept) begin
                if (in_last) begin
                    wr_ptr    <= '0;
                    pkt_ready <= 1'b1;
                    receiving <= 1'b0; // The pulse takes over the busy indication.
                end else begin
                    wr_ptr    <= wr_ptr + 1'b1;
                    receiving <= 1'b1;
                end
            end
        end
    end

    // The length is a payload register. It is only looked at while pkt_ready
    // is high, and it is loaded at the same edge that raises pkt_ready.
    always_ff @(posedge clk) begin
        if (accept && in_last) begin
            pkt_len <= pkt_pkg::pkt_len_t'(wr_ptr) + 1'b1; // Last index plus one.
        end
    end

endmodule

// ==== source/fwd_width_adapter.sv ====
`timescale 1ns/1ns

module fwd_width_adapter (
    input  logic               clk,
    input  pkt_pkg::fwd_addr_t fwd_addr,    // Narrow word address from the forwarder.
    output pkt_pkg::fwd_word_t fwd_rd_data, // Narrow word, MEM_LAT cycles later.
    output pkt_pkg::mem_addr_t mem_addr,    // Wide word address into the memory.
    input  pkt_pkg::mem_word_t mem_rd_data
);

    // The offset of the narrow word inside its wide word. It has to travel
    // alongside the memory read so that it meets the data it belongs to.
    logic [pkt_pkg::OFS_WIDTH-1:0] offset_pipe [pkt_pkg::MEM_LAT];
    logic [pkt_pkg::OFS_WIDTH-1:0] lane_sel;

    // The wide read word split into its narrow lanes, lane 0 at the bottom.
    pkt_pkg::fwd_word_t lanes [pkt_pkg::RATIO];

    // The upper address bits address the wide word directly. There is no delay
    // on this path, the memory adds its own latency.
    assign mem_addr = fwd_addr[pkt_pkg::FWD_ADDR_WIDTH-1:pkt_pkg::OFS_WIDTH];

    // Offset delay chain, as deep as the memory read.
    always_ff @(posedge clk) begin
        offset_pipe[0] <= fwd_addr[pkt_pkg::OFS_WIDTH-1:0];
        for (int i = 1; i < pkt_pkg::MEM_LAT; i++) begin
            offset_pipe[i] <= offset_pipe[i-1];
        end
    end

    always_comb begin
        for (int i = 0; i < pkt_pkg::RATIO; i++) begin
            lanes[i] = mem_rd_data[i*pkt_pkg::FWD_WIDTH +: pkt_pkg::FWD_WIDTH];
        end
    end

    // Offset 0 is the most significant lane. The snooper writes in this same
    // order, so the words come back out in the order they went in.
    assign lane_sel = pkt_pkg::OFS_WIDTH'(pkt_pkg::RATIO - 1)
                    - offset_pipe[pkt_pkg::MEM_LAT-1];

    assign fwd_rd_data = lanes[lane_sel];

endmodule

// ==== source/forwarder.sv ====
`timescale 1ns/1ns

module forwarder (
    input  logic               clk,
    input  logic               reset,
    input  logic               pkt_ready,   // A complete packet sits in the memory.
    input  pkt_pkg::pkt_len_t  pkt_len,     // Its length, valid with pkt_ready.
    output pkt_pkg::fwd_addr_t fwd_addr,    // Narrow read address to the adapter.
    input  pkt_pkg::fwd_word_t fwd_rd_data, // Read data, MEM_LAT cycles behind.
    output logic               out_valid,
    output logic               out_last,
    output pkt_pkg::fwd_word_t out_data,
    output logic               fwd_busy     // Held until the last word has left.
);

    pkt_pkg::fwd_state_t state;
    pkt_pkg::fwd_addr_t  rd_addr;   // Address issued this cycle.
    pkt_pkg::fwd_addr_t  last_addr; // Address of the final word of the packet.
    logic                rd_en;     // A read is issued this cycle.
    logic                rd_last;   // The read issued this cycle is the final one.

    // One flag per cycle of read latency. Bit MEM_LAT-1 lines up with the data.
    logic [pkt_pkg::MEM_LAT-1:0] valid_pipe;
    logic [pkt_pkg::MEM_LAT-1:0] last_pipe;

    assign fwd_addr = rd_addr;
    assign rd_en    = (state == pkt_pkg::send);
    assign rd_last  = rd_en && (rd_addr == last_addr);

    // The FSM issues one read per cycle with no gaps, from address 0 up to the
    // last address, then drops back to idle.
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= pkt_pkg::idle;
            rd_addr <= '0;
        end else begin
            unique case (state)
                pkt_pkg::idle: begin
                    if (pkt_ready) begin
                        state   <= pkt_pkg::send;
                        rd_addr <= '0; // Every packet starts at word 0.
                    end
                end
                pkt_pkg::send: begin
                    if (rd_last) begin
                        state <= pkt_pkg::idle;
                    end else begin
                        rd_addr <= rd_addr + 1'b1;
                    end
                end
                default: state <= pkt_pkg::idle;
            endcase
        end
    end

    // The length is latched as the index of the final word. A 1024-word packet
    // gives 1023, which still fits in a narrow address.
    always_ff @(posedge clk) begin
        if (state == pkt_pkg::idle && pkt_ready) begin
            last_addr <= pkt_pkg::fwd_addr_t'(pkt_len - 1'b1);
        end
    end

    // Issue and last flags ride along with the read for MEM_LAT cycles, so
    // the output strobes come out together with the matching data word.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
            last_pipe  <= '0;
        end else begin
            valid_pipe[0] <= rd_en;
            last_pipe[0]  <= rd_last;
            for (int i = 1; i < pkt_pkg::MEM_LAT; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
                last_pipe[i]  <= last_pipe[i-1];
            end
        end
    end

    assign out_valid = valid_pipe[pkt_pkg::MEM_LAT-1];
    assign out_last  = last_pipe[pkt_pkg::MEM_LAT-1];
    assign out_data  = fwd_rd_data; // Already aligned by the adapter.

    // Busy covers the reads still in flight after the FSM has gone idle, so it
    // falls in the cycle after out_last.
    assign fwd_busy = rd_en || (|valid_pipe);

endmodule

// ==== source/pkt_buffer_top.sv ====
`timescale 1ns/1ns

module pkt_buffer_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  logic               in_last,
    input  pkt_pkg::fwd_word_t in_data,
    output logic               out_valid,
    output logic               out_last,
    output pkt_pkg::fwd_word_t out_data,
    output logic               busy      // Upstream holds off while this is high.
);

    pkt_pkg::mem_wr_t   mem_wr;      // Snooper writes into the memory.
    pkt_pkg::mem_addr_t mem_addr;    // Wide read address from the adapter.
    pkt_pkg::mem_word_t mem_rd_data; // Wide read data back to the adapter.
    pkt_pkg::fwd_addr_t fwd_addr;    // Narrow read address from the forwarder.
    pkt_pkg::fwd_word_t fwd_rd_data; // Narrow read data to the forwarder.
    pkt_pkg::pkt_len_t  pkt_len;
    logic               pkt_ready;
    logic               receiving;
    logic               fwd_busy;

    // The buffer is busy from the first stored word until the last word out.
    assign busy = receiving || pkt_ready || fwd_busy;

    snooper u_snooper (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_data   (in_data),
        .fwd_busy  (fwd_busy),
        .mem_wr    (mem_wr),
        .pkt_ready (pkt_ready),
        .pkt_len   (pkt_len),
        .receiving (receiving)
    );

    packet_mem u_packet_mem (
        .clk         (clk),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_rd_data (mem_rd_data)
    );

    fwd_width_adapter u_fwd_width_adapter (
        .clk         (clk),
        .fwd_addr    (fwd_addr),
        .fwd_rd_data (fwd_rd_data),
        .mem_addr    (mem_addr),
        .mem_rd_data (mem_rd_data)
    );

    forwarder u_forwarder (
        .clk         (clk),
        .reset       (reset),
        .pkt_ready   (pkt_ready),
        .pkt_len     (pkt_len),
        .fwd_addr    (fwd_addr),
        .fwd_rd_data (fwd_rd_data),
        .out_valid   (out_valid),
        .out_last    (out_last),
        .out_data    (out_data),
        .fwd_busy    (fwd_busy)
    );

endmodule

// ==== sim/pkt_buffer_checker.sv ====
`timescale 1ns/1ns

module pkt_buffer_checker (
    input logic clk,
    input logic reset,
    input logic in_valid,
    input logic pkt_ready, // Hand-over pulse from the snooper.
    input logic fwd_busy,  // The forwarder is still streaming.
    input logic out_valid,
    input logic out_last
);

    // The busy level also covers the packet that is arriving, so a word is only
    // illegal while the previous packet is handed over or forwarded.
    in_valid_while_busy: assert property (@(posedge clk) disable iff (reset)
        !(in_valid && (pkt_ready || fwd_busy)))
        else $error("in_valid was high while the buffer still held the previous packet");

    // The last strobe marks a data word, so it never stands alone.
    last_without_valid: assert property (@(posedge clk) disable iff (reset)
        out_last |-> out_valid)
        else $error("out_last was high without out_valid");

    // One packet gives exactly one hand-over pulse.
    ready_pulse_width: assert property (@(posedge clk) disable iff (reset)
        pkt_ready |=> !pkt_ready)
        else $error("pkt_ready stayed high for two cycles in a row");

    // The first edge of reset clears the output pipeline, so only later cycles count.
    valid_in_reset: assert property (@(posedge clk)
        (reset && $past(reset)) |-> !out_valid)
        else $error("out_valid was high during reset");

endmodule

// Attach the checker to every instance of the top level.
bind pkt_buffer_top pkt_buffer_checker chk0 (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .pkt_ready (pkt_ready),
    .fwd_busy  (fwd_busy),
    .out_valid (out_valid),
    .out_last  (out_last)
);

// ==== sim/pkt_buffer_tb.sv ====
`timescale 1ns/1ns

module pkt_buffer_tb;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_RANDOM   = 20;
    localparam int FULL_LEN     = 1024; // Largest packet the memory can hold.

    logic               clk = 1'b0;
    logic               reset;
    logic               in_valid;
    logic               in_last;
    pkt_pkg::fwd_word_t in_data;
    logic               out_valid;
    logic               out_last;
    pkt_pkg::fwd_word_t out_data;
    logic               busy;

    // Reference model. Words and lengths are queued as they are sent and
    // popped as the DUT forwards them, since packets leave in arrival order.
    pkt_pkg::fwd_word_t exp_q[$];
    int                 len_q[$];
    int                 accept_q[$]; // Edge number at which each in_last is taken.

    logic [31:0] rng_state = 32'h9654;
    int          cyc = 0;            // Rising edges seen so far.
    int          cycle_limit = 0;    // Zero until the test lengths are known.
    int          checks = 0;
    int          errors = 0;
    int          word_count = 0;     // Words of the current packet seen at the output.
    int          prev_cyc = 0;       // Cycle of the previous output word.
    bit          busy_check_due = 0; // Set at out_last to look at busy one cycle later.
    int          rand_len [NUM_RANDOM];

    pkt_buffer_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_data  (out_data),
        .busy      (busy)
    );

    always #2 clk = ~clk; // 4 ns period.

    // Compares one observed value with the expected one.
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Linear congruential generator. The upper bits are the better ones.
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    // Cycle budget of one packet. It covers arrival with gaps, forwarding and slack.
    function automatic int packet_budget(input int len);
        return 3 * len + 40;
    endfunction

    // Waits for the buffer to be free, then sends one packet.
    task automatic send_packet(input int len, input bit gaps);
        logic [31:0] r;
        do begin
            @(posedge clk);
            #1;
        end while (busy);
        len_q.push_back(len);
        for (int i = 0; i < len; i++) begin
            if (i > 0) begin
                @(posedge clk);
                #1;
                r = next_random();
                if (gaps && r[17:16] == 2'b00) begin
                    in_valid = 1'b0; // One idle cycle inside the packet.
                    @(posedge clk);
                    #1;
                end
            end
            in_data  = next_random();
            in_valid = 1'b1;
            in_last  = (i == len - 1);
            exp_q.push_back(in_data);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    // Waits until every queued word has come out and the buffer is idle.
    task automatic wait_drained();
        do begin
            @(posedge clk);
            #1;
        end while (busy || exp_q.size() != 0);
    endtask

    task automatic report_test(input string name);
        $display("test %s finished, %0d errors so far", name, errors);
    endtask

    // Edge counter and watchdog.
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cycle_limit > 0 && cyc >= cycle_limit) begin
            $display("error: timeout after %0d cycles, the DUT stopped forwarding", cyc);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Output monitor. Outputs change just after a rising edge, so the falling
    // edge sees them settled.
    always @(negedge clk) begin
        if (!reset) begin
            if (busy_check_due) begin
                check_value("busy after out_last", busy, 0);
                busy_check_due = 0;
            end
            if (in_valid && in_last) begin
                accept_q.push_back(cyc + 1); // Taken at the coming edge.
            end
            if (out_valid) begin
                if (exp_q.size() == 0 || len_q.size() == 0
                        || (word_count == 0 && accept_q.size() == 0)) begin
                    errors++;
                    $display("error at %0t ns: an output word came with no packet sent",
                             $time);
                end else begin
                    if (word_count == 0) begin
                        check_value("first out_valid cycle", cyc, accept_q.pop_front() + 2);
                    end else begin
                        check_value("out_valid cycle", cyc, prev_cyc + 1); // No gaps.
                    end
                    prev_cyc = cyc;
                    word_count++;
                    check_value("out_data", out_data, exp_q.pop_front());
                    check_value("out_last", out_last, word_count == len_q[0]);
                    if (out_last) begin
                        check_value("word count", word_count, len_q.pop_front());
                        check_value("busy at out_last", busy, 1);
                        word_count     = 0;
                        busy_check_due = 1;
                    end
                end
            end
        end
    end

    initial begin
        int total;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_last  = 1'b0;
        in_data  = '0;

        // Random lengths alternate odd and even and run from 1 to 64 words.
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rand_len[i] = 2 * int'((next_random() >> 12) % 32) + 1 + (i % 2);
        end
        total = RESET_CYCLES + packet_budget(1) + packet_budget(2) + packet_budget(5);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            total += packet_budget(rand_len[i]);
        end
        total += packet_budget(FULL_LEN);
        cycle_limit = total;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // Outputs are quiet before the first word goes in.
        check_value("out_valid after reset", out_valid, 0);
        check_value("out_last after reset", out_last, 0);
        check_value("busy after reset", busy, 0);
        report_test("reset");

        // One word uses the upper lane only, two words fill both lanes.
        send_packet(1, 1'b0);
        wait_drained();
        send_packet(2, 1'b0);
        wait_drained();
        report_test("short packets");

        // The monitor checks the two-edge latency and the back-to-back words.
        send_packet(5, 1'b0);
        wait_drained();
        report_test("latency");

        for (int i = 0; i < NUM_RANDOM; i++) begin
            send_packet(rand_len[i], 1'b1);
        end
        wait_drained();
        report_test("random packets");

        send_packet(FULL_LEN, 1'b0);
        wait_drained();
        repeat (2) @(posedge clk); // Lets the monitor look at busy after out_last.
        report_test("full packet");

        if (exp_q.size() != 0) begin
            errors++;
            $display("error: %0d expected words never came out", exp_q.size());
        end
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== files.f ====
source/pkt_pkg.sv
source/packet_mem.sv
source/snooper.sv
source/fwd_width_adapter.sv
source/forwarder.sv
source/pkt_buffer_top.sv
sim/pkt_buffer_checker.sv
sim/pkt_buffer_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the packet buffer testbench with Verilator and runs it once.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f files.f \
    --top-module pkt_buffer_tb \
    -o pkt_buffer_sim

./obj_dir/pkt_buffer_sim | tee sim.log

# The testbench prints the pass line only when every check held.
if grep -q '^>>> PASS$' sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
